/* cache_cfg_pkg.sv */
package cache_cfg_pkg;

    localparam int ADDR_W          = 16;                        // byte address width
    localparam int WORD_W          = 16;                        // instruction word width
    localparam int OFFSET_W        = 4;                         // byte offset inside a 16-byte block
    localparam int INDEX_W         = 5;                         // set index bits, 32 sets
    localparam int TAG_W           = 7;                         // what is left of the address
    localparam int WORDS_PER_BLOCK = 8;                         // words fetched on every refill
    localparam int WORD_BYTES      = 2;                         // fetch address step between words

    localparam int WORD_SEL_W      = $clog2(WORDS_PER_BLOCK);   // word-in-block bits of the offset
    localparam int BYTE_SEL_W      = OFFSET_W - WORD_SEL_W;     // byte-in-word bits, always zero here
    localparam int SETS            = 1 << INDEX_W;              // direct mapped, one line per set
    localparam int DATA_WORDS      = SETS * WORDS_PER_BLOCK;    // depth of the data array
    localparam int WORD_CNT_W      = WORD_SEL_W;                // refill word counter width

    // the offset splits into the word inside the block and the byte inside the word
    typedef struct packed {
        logic [WORD_SEL_W-1:0] word;                            // selects one of eight words
        logic [BYTE_SEL_W-1:0] byte_sel;                        // ignored since fetches are word aligned
    } block_offset_t;

    // field view of an address as the arrays see it
    typedef struct packed {
        logic [TAG_W-1:0]   tag;                                // compared against the stored tag
        logic [INDEX_W-1:0] index;                              // picks the set
        block_offset_t      offset;                             // position inside the block
    } cache_addr_fields_t;

    // buses carry the raw word while the arrays decode the fields of the same bits
    typedef union packed {
        logic [ADDR_W-1:0]  raw;                                // flat byte address
        cache_addr_fields_t f;                                  // tag, index and offset view
    } cache_addr_u;

    // one entry of the tag store
    typedef struct packed {
        logic             valid;                                // line holds a complete block
        logic [TAG_W-1:0] tag;                                  // upper address bits of that block
    } tag_entry_t;

endpackage

/* cache_bus_pkg.sv */
package cache_bus_pkg;

    import cache_cfg_pkg::*;

    localparam int MEM_LATENCY = 4;                             // cycles from read pulse to data pulse
    localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);       // counter must reach MEM_LATENCY

    // requester side of the four-phase handshake
    typedef struct packed {
        logic              req;                                 // held high until ack is seen
        logic [ADDR_W-1:0] addr;                                // byte address of the wanted word
    } cpu_req_t;

    // cache answer to the requester
    typedef struct packed {
        logic              ack;                                 // data below is valid while this is high
        logic [WORD_W-1:0] data;                                // the fetched instruction word
    } cpu_resp_t;

    // one-cycle read pulse toward main memory
    typedef struct packed {
        logic              valid;                               // pulses once per word read
        logic [ADDR_W-1:0] addr;                                // word aligned byte address
    } mem_rd_req_t;

    // memory answers exactly MEM_LATENCY cycles after the request
    typedef struct packed {
        logic              valid;                               // one-cycle data pulse
        logic [WORD_W-1:0] data;                                // word at the requested address
    } mem_rd_resp_t;

endpackage

/* cache_tag_array.sv */
`timescale 1ns/1ps

module cache_tag_array
    import cache_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  cache_addr_u lookup_addr,
    input  logic        tag_wr,
    input  cache_addr_u fill_addr,
    input  logic        flush,
    output logic        hit
);

    tag_entry_t tags_q [SETS];                                  // one entry per set
    tag_entry_t lookup_entry;                                   // entry selected by the lookup index

    assign lookup_entry = tags_q[lookup_addr.f.index];

    // a hit needs a valid line whose stored tag matches the lookup tag
    assign hit = lookup_entry.valid && (lookup_entry.tag == lookup_addr.f.tag);

    // only the valid bits are cleared, stale tags are harmless once invalid
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int s = 0; s < SETS; s++) begin
                tags_q[s].valid <= 1'b0;                        // whole cache becomes empty
            end
        end else if (tag_wr) begin
            tags_q[fill_addr.f.index].valid <= 1'b1;            // block is complete in the data array
            tags_q[fill_addr.f.index].tag   <= fill_addr.f.tag; // remember which block it is
        end
    end

    // flush comes through the controller and tag writes come from the refill machine
    // so the two must never land on the same edge
    a_no_flush_during_fill : assert property (
        @(posedge clk) disable iff (reset)
        !(tag_wr && flush)
    ) else $error("tag write and flush in the same cycle");

endmodule

/* cache_data_array.sv */
`timescale 1ns/1ps

module cache_data_array
    import cache_cfg_pkg::*;
(
    input  logic              clk,
    input  cache_addr_u       rd_addr,
    output logic [WORD_W-1:0] rd_data,
    input  logic              data_wr,
    input  cache_addr_u       wr_addr,
    input  logic [WORD_W-1:0] wr_data
);

    localparam int IDX_W = INDEX_W + WORD_SEL_W;                // set and word together address a word

    logic [WORD_W-1:0] words_q [DATA_WORDS];                    // every word of every cached block
    logic [IDX_W-1:0]  rd_idx;                                  // flat read position
    logic [IDX_W-1:0]  wr_idx;                                  // flat write position

    // the byte select bit is dropped since every access is a whole word
    assign rd_idx = {rd_addr.f.index, rd_addr.f.offset.word};
    assign wr_idx = {wr_addr.f.index, wr_addr.f.offset.word};

    // refill writes one word per memory response
    always_ff @(posedge clk) begin
        if (data_wr) begin
            words_q[wr_idx] <= wr_data;                         // lands in the cycle of the response
        end
    end

    // registered read so the word is ready one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= words_q[rd_idx];                             // read before write on a clash
    end

endmodule

/* cache_fill_fsm.sv */
`timescale 1ns/1ps

module cache_fill_fsm
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              fill_start,
    input  cache_addr_u       miss_addr,
    output logic              fill_busy,
    output mem_rd_req_t       mem_rd_req,
    input  mem_rd_resp_t      mem_rd_resp,
    output logic              data_wr,
    output cache_addr_u       wr_addr,
    output logic [WORD_W-1:0] wr_data,
    output logic              tag_wr
);

    typedef enum logic {
        ST_IDLE,                                                // waiting for a miss
        ST_FILL                                                 // fetching the block word by word
    } fill_state_t;

    fill_state_t           state_q;
    logic [LAT_CNT_W-1:0]  lat_cnt_q;                           // cycles since the open read, zero when none
    logic [WORD_CNT_W-1:0] word_cnt_q;                          // responses received so far
    cache_addr_u           fetch_addr_q;                        // address of the read in flight
    logic                  rd_issue;                            // a new read goes out this cycle
    logic                  last_word;                           // counter sits on the final word

    assign rd_issue  = (state_q == ST_FILL) && (lat_cnt_q == '0);
    assign last_word = word_cnt_q == WORD_CNT_W'(WORDS_PER_BLOCK - 1);

    assign data_wr   = (state_q == ST_FILL) && mem_rd_resp.valid; // every response is written
    assign tag_wr    = data_wr && last_word;                    // tag goes in with the eighth word
    assign wr_addr   = fetch_addr_q;                            // response belongs to the open read
    assign wr_data   = mem_rd_resp.data;
    assign fill_busy = state_q == ST_FILL;                      // drops in the cycle after the tag write

    assign mem_rd_req.valid = rd_issue;
    assign mem_rd_req.addr  = fetch_addr_q.raw;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (fill_start) state_q <= ST_FILL;    // controller saw a miss
                ST_FILL: if (tag_wr) state_q <= ST_IDLE;        // whole block is in place
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // the latency counter starts at one with the read and parks at MEM_LATENCY
    // until data comes back, so a nonzero value means a read is outstanding
    always_ff @(posedge clk) begin
        if (reset) begin
            lat_cnt_q <= '0;
        end else if (data_wr) begin
            lat_cnt_q <= '0;                                    // next read may go out next cycle
        end else if (rd_issue) begin
            lat_cnt_q <= LAT_CNT_W'(1);
        end else if (lat_cnt_q != '0 && lat_cnt_q != LAT_CNT_W'(MEM_LATENCY)) begin
            lat_cnt_q <= lat_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            word_cnt_q <= '0;
        end else if (data_wr) begin
            word_cnt_q <= word_cnt_q + 1'b1;                    // wraps to zero after the last word
        end
    end

    // the block base keeps tag and index of the miss with a cleared offset
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && fill_start) begin
            fetch_addr_q.f.tag    <= miss_addr.f.tag;
            fetch_addr_q.f.index  <= miss_addr.f.index;
            fetch_addr_q.f.offset <= '0;
        end else if (data_wr) begin
            fetch_addr_q.raw <= fetch_addr_q.raw + ADDR_W'(WORD_BYTES); // step to the next word
        end
    end

    a_one_read_outstanding : assert property (
        @(posedge clk) disable iff (reset)
        mem_rd_req.valid |=> !mem_rd_req.valid [*MEM_LATENCY]
    ) else $error("memory read issued while another is outstanding");

    a_resp_only_in_fill : assert property (
        @(posedge clk) disable iff (reset)
        mem_rd_resp.valid |-> state_q == ST_FILL && lat_cnt_q == LAT_CNT_W'(MEM_LATENCY)
    ) else $error("memory response arrived outside a refill or off its latency");

    a_start_only_in_idle : assert property (
        @(posedge clk) disable iff (reset)
        fill_start |-> state_q == ST_IDLE
    ) else $error("refill requested while a refill is running");

endmodule

/* cache_access_ctrl.sv */
`timescale 1ns/1ps

module cache_access_ctrl
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  cpu_req_t          cpu_req,
    output cpu_resp_t         cpu_resp,
    output cache_addr_u       lookup_addr,
    input  logic              hit,
    input  logic [WORD_W-1:0] rd_data,
    output logic              fill_start,
    input  logic              fill_busy,
    input  logic              flush_req,
    output logic              flush
);

    typedef enum logic [2:0] {
        ST_IDLE,                                                // no request, flush allowed
        ST_LOOKUP,                                              // tag compare on the latched address
        ST_READ,                                                // data array word is on rd_data
        ST_ACK_WAIT,                                            // ack high until req drops
        ST_FILL_WAIT,                                           // refill in progress
        ST_RELEASE                                              // ack just dropped, flush still held off
    } ctrl_state_t;

    ctrl_state_t       state_q, state_d;
    cache_addr_u       addr_q;                                  // request address for lookup and refill
    logic              ack_q;
    logic [WORD_W-1:0] data_q;                                  // held for as long as ack is high
    logic              accept;                                  // a new request is taken this cycle

    assign accept      = (state_q == ST_IDLE || state_q == ST_RELEASE) && cpu_req.req;
    assign lookup_addr = addr_q;
    assign fill_start  = (state_q == ST_LOOKUP) && !hit;        // one pulse per miss
    assign flush       = flush_req && (state_q == ST_IDLE);     // never during a lookup or refill
    assign cpu_resp    = '{ack: ack_q, data: data_q};

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE,
            ST_RELEASE:   state_d = cpu_req.req ? ST_LOOKUP : ST_IDLE;
            ST_LOOKUP:    state_d = hit ? ST_READ : ST_FILL_WAIT;
            ST_READ:      state_d = ST_ACK_WAIT;
            ST_ACK_WAIT:  if (!cpu_req.req) state_d = ST_RELEASE; // four-phase return to zero
            ST_FILL_WAIT: if (!fill_busy) state_d = ST_LOOKUP;    // block landed, look again
            default:      state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_READ) begin
                ack_q <= 1'b1;                                  // two edges after req was taken
            end else if (state_q == ST_ACK_WAIT && !cpu_req.req) begin
                ack_q <= 1'b0;                                  // one edge after req is seen low
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) addr_q.raw <= cpu_req.addr;                 // requester holds it stable anyway
        if (state_q == ST_READ) data_q <= rd_data;              // registered word from the array
    end

    a_ack_follows_req : assert property (
        @(posedge clk) disable iff (reset)
        (!cpu_req.req && $past(!cpu_req.req)) |-> !cpu_resp.ack
    ) else $error("ack still high after req stayed low for two cycles");

endmodule

/* icache_top.sv */
`timescale 1ns/1ps

module icache_top
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         flush_req,
    input  cpu_req_t     cpu_req,
    output cpu_resp_t    cpu_resp,
    output mem_rd_req_t  mem_rd_req,
    input  mem_rd_resp_t mem_rd_resp
);

    cache_addr_u       lookup_addr;                             // shared by tag compare and data read
    cache_addr_u       wr_addr;                                 // refill word position, also names the tag
    logic              hit;
    logic [WORD_W-1:0] rd_data;
    logic [WORD_W-1:0] wr_data;
    logic              fill_start;
    logic              fill_busy;
    logic              flush;                                   // flush_req after the idle gate
    logic              data_wr;
    logic              tag_wr;

    cache_access_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_resp    (cpu_resp),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .rd_data     (rd_data),
        .fill_start  (fill_start),
        .fill_busy   (fill_busy),
        .flush_req   (flush_req),
        .flush       (flush)
    );

    cache_tag_array u_tags (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .tag_wr      (tag_wr),
        .fill_addr   (wr_addr),                                 // last word address carries tag and index
        .flush       (flush),
        .hit         (hit)
    );

    cache_data_array u_data (
        .clk         (clk),
        .rd_addr     (lookup_addr),
        .rd_data     (rd_data),
        .data_wr     (data_wr),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    cache_fill_fsm u_fill (
        .clk         (clk),
        .reset       (reset),
        .fill_start  (fill_start),
        .miss_addr   (lookup_addr),                             // the address that just missed
        .fill_busy   (fill_busy),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_resp (mem_rd_resp),
        .data_wr     (data_wr),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .tag_wr      (tag_wr)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    localparam time HALF_PERIOD = 50ns;                         // 100 ns clock period

    initial begin
        clk = 1'b0;                                             // first rising edge lands at 50 ns
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

/* tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  mem_rd_req_t  mem_rd_req,
    output mem_rd_resp_t mem_rd_resp,
    output int           read_count
);

    mem_rd_req_t pipe_q [MEM_LATENCY];                          // reads in flight, oldest at the end

    // the content of every word follows from its full address
    // low address byte xor 3c sits in the upper data byte
    function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] a);
        return {a[7:0] ^ 8'h3c, a[15:8]};
    endfunction

    initial begin
        mem_rd_resp = '0;                                       // bus is quiet before the first falling edge
        read_count  = 0;
    end

    // sampled and driven on the falling edge, so the cache sees stable inputs at its rising edge
    // a read seen in cycle c comes back as a one-cycle pulse in cycle c + MEM_LATENCY
    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                pipe_q[i] <= '0;                                // nothing in flight after reset
            end
            mem_rd_resp <= '0;
            read_count  <= 0;
        end else begin
            pipe_q[0] <= mem_rd_req;                            // every cycle enters, valid or not
            for (int i = 1; i < MEM_LATENCY; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
            mem_rd_resp.valid <= pipe_q[MEM_LATENCY-1].valid;
            mem_rd_resp.data  <= word_at(pipe_q[MEM_LATENCY-1].addr);
            if (mem_rd_req.valid) begin
                read_count <= read_count + 1;                   // total reads since reset
            end
        end
    end

endmodule

/* tb_icache.sv */
`timescale 1ns/1ps

module tb_icache
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
();

    localparam int          TABLE_LEN      = 15;
    localparam int          RAND_COUNT     = 40;
    localparam int          TIMEOUT_CYCLES = (TABLE_LEN + RAND_COUNT) * 60 + 100;
    localparam int          HIT_EDGES      = 3;                 // req seen at edge n and ack after n+2
    localparam int          HOLD_CYCLES    = 2;                 // extra cycles req stays high after ack
    localparam logic [31:0] SEED           = 32'h363d0f3c;

    typedef enum logic {
        OP_READ,
        OP_FLUSH
    } op_t;

    // one row of the directed table, reads holds the running total of memory reads
    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
        logic [31:0]       reads;
    } stim_entry_t;

    logic              clk;
    logic              reset;
    logic              flush_req;
    cpu_req_t          cpu_req;
    cpu_resp_t         cpu_resp;
    mem_rd_req_t       mem_rd_req;
    mem_rd_resp_t      mem_rd_resp;
    int                read_count;                              // reads seen by the memory model
    int                exp_reads;                               // reads expected so far
    stim_entry_t       stim_table [TABLE_LEN];
    logic              mirror_valid [SETS];                     // reference copy of the tag store
    logic [TAG_W-1:0]  mirror_tag [SETS];
    logic [ADDR_W-1:0] next_fill_addr;                          // address the next memory read must use
    logic              req_at_edge;                             // req as the cache sampled it
    logic              ack_prev;
    logic              monitor_on;

    tb_clock_gen u_clk (.clk(clk));

    tb_mem_model u_mem (
        .clk         (clk),
        .reset       (reset),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_resp (mem_rd_resp),
        .read_count  (read_count)
    );

    icache_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .flush_req   (flush_req),
        .cpu_req     (cpu_req),
        .cpu_resp    (cpu_resp),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_resp (mem_rd_resp)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH time %0t %s actual %0h expected %0h", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    // word content by the memory rule, upper byte is the low address byte xor 3c
    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
        return {a[7:0] ^ 8'h3c, a[15:8]};
    endfunction

    task automatic fill_table();
        stim_table[0]  = '{OP_READ,  16'h1234, 16'h0812, 32'd8};  // cold miss, set 3 tag 09
        stim_table[1]  = '{OP_READ,  16'h123a, 16'h0612, 32'd8};  // same block hits
        stim_table[2]  = '{OP_READ,  16'h1230, 16'h0c12, 32'd8};  // first word of the block
        stim_table[3]  = '{OP_READ,  16'h123e, 16'h0212, 32'd8};  // last word of the block
        stim_table[4]  = '{OP_READ,  16'h5234, 16'h0852, 32'd16}; // set 3 with tag 29 evicts
        stim_table[5]  = '{OP_READ,  16'h1234, 16'h0812, 32'd24}; // evicted block misses again
        stim_table[6]  = '{OP_READ,  16'h0040, 16'h7c00, 32'd32}; // set 4 tag 00
        stim_table[7]  = '{OP_READ,  16'h0046, 16'h7a00, 32'd32};
        stim_table[8]  = '{OP_READ,  16'hfffe, 16'hc2ff, 32'd40}; // top set and top tag
        stim_table[9]  = '{OP_FLUSH, 16'h0000, 16'h0000, 32'd40};
        stim_table[10] = '{OP_READ,  16'h0046, 16'h7a00, 32'd48}; // was resident before the flush
        stim_table[11] = '{OP_READ,  16'h1238, 16'h0412, 32'd56};
        stim_table[12] = '{OP_READ,  16'h1232, 16'h0e12, 32'd56};
        stim_table[13] = '{OP_READ,  16'habcc, 16'hf0ab, 32'd64}; // set 1c tag 55
        stim_table[14] = '{OP_READ,  16'habc0, 16'hfcab, 32'd64};
    endtask

    // one full four-phase read, exp_total equal to exp_reads means a hit is expected
    task automatic read_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] exp_data,
                             input int exp_total);
        int   edges;
        logic was_hit;
        edges   = 0;
        was_hit = (exp_total == exp_reads);
        @(negedge clk);
        next_fill_addr = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}; // a refill starts at the base
        cpu_req = '{req: 1'b1, addr: addr};
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!cpu_resp.ack);
        if (was_hit) begin
            check_value("ack latency in edges", 32'(edges), 32'(HIT_EDGES));
        end
        check_value("cpu_resp.data", 32'(cpu_resp.data), 32'(exp_data));
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_value("cpu_resp.ack while req held", 32'(cpu_resp.ack), 32'd1);
            check_value("cpu_resp.data while req held", 32'(cpu_resp.data), 32'(exp_data));
        end
        cpu_req.req = 1'b0;
        @(negedge clk);
        check_value("cpu_resp.ack after req low", 32'(cpu_resp.ack), 32'd0);
        check_value("read_count", 32'(read_count), 32'(exp_total));
        if (!was_hit) begin
            mirror_valid[addr[OFFSET_W +: INDEX_W]] = 1'b1;
            mirror_tag[addr[OFFSET_W +: INDEX_W]]   = addr[ADDR_W-1 -: TAG_W];
        end
        exp_reads = exp_total;
    endtask

    task automatic flush_cache(input int exp_total);
        @(negedge clk);
        flush_req = 1'b1;
        repeat (2) @(posedge clk);                              // first edge may still find the release state
        @(negedge clk);
        flush_req = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            mirror_valid[s] = 1'b0;
        end
        check_value("read_count after flush", 32'(read_count), 32'(exp_total));
    endtask

    always @(posedge clk) begin
        req_at_edge <= cpu_req.req;                             // same value the controller sampled
    end

    // handshake and refill order are watched on every falling edge
    always @(negedge clk) begin
        if (monitor_on) begin
            if (cpu_resp.ack && !ack_prev && !req_at_edge) begin
                fail_run("ack rose although req was low");
            end
            if (mem_rd_req.valid) begin
                check_value("mem_rd_req.addr", 32'(mem_rd_req.addr), 32'(next_fill_addr));
                next_fill_addr = next_fill_addr + 16'(WORD_BYTES);
            end
        end
        ack_prev = cpu_resp.ack;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                fail_run($sformatf("timeout after %0d cycles, the cache stopped answering", cycles));
            end
        end
    end

    initial begin : stimulus
        logic [31:0]       first_draw;
        logic [TAG_W-1:0]  rand_tag;
        logic [INDEX_W-1:0] rand_index;
        logic [2:0]        rand_word;
        logic [ADDR_W-1:0] addr;
        logic              hit;
        int                total;
        first_draw     = $urandom(SEED);                        // seeds the generator once
        reset          = 1'b1;
        flush_req      = 1'b0;
        cpu_req        = '0;
        monitor_on     = 1'b0;
        ack_prev       = 1'b0;
        exp_reads      = 0;
        next_fill_addr = '0;
        for (int s = 0; s < SETS; s++) begin
            mirror_valid[s] = 1'b0;
            mirror_tag[s]   = '0;
        end
        fill_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset      = 1'b0;
        monitor_on = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("cpu_resp.ack after reset", 32'(cpu_resp.ack), 32'd0);
            check_value("mem_rd_req.valid after reset", 32'(mem_rd_req.valid), 32'd0);
            check_value("fill_busy after reset", 32'(dut0.fill_busy), 32'd0);
            check_value("data_wr after reset", 32'(dut0.data_wr), 32'd0);
            check_value("tag_wr after reset", 32'(dut0.tag_wr), 32'd0);
        end
        for (int i = 0; i < TABLE_LEN; i++) begin
            if (stim_table[i].op == OP_FLUSH) begin
                flush_cache(int'(stim_table[i].reads));
            end else begin
                read_word(stim_table[i].addr, stim_table[i].data, int'(stim_table[i].reads));
            end
        end
        // few tags over few sets so hits, conflicts and flushes all occur
        for (int i = 0; i < RAND_COUNT; i++) begin
            if ($urandom % 8 == 0) begin
                flush_cache(exp_reads);
            end else begin
                rand_tag   = 7'($urandom % 3);
                rand_index = 5'($urandom % 4);
                rand_word  = 3'($urandom);
                addr       = {rand_tag, rand_index, rand_word, 1'b0};
                hit        = mirror_valid[rand_index] && (mirror_tag[rand_index] == rand_tag);
                total      = hit ? exp_reads : exp_reads + WORDS_PER_BLOCK;
                read_word(addr, expected_word(addr), total);
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule

/* icache.f */
cache_cfg_pkg.sv
cache_bus_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_fill_fsm.sv
cache_access_ctrl.sv
icache_top.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_icache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile with Verilator and run, the exit status is the simulator's own

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    -f icache.f \
    --top-module tb_icache \
    -Mdir obj_dir -o sim_icache &&
./obj_dir/sim_icache ||
{ echo "simulation failed" >&2; exit 1; }
